//--- rtl/sw_pkg.sv
// Alignment engine package with sizes, scoring weights, FSM codes and shared types
`default_nettype none

package sw_pkg;

    localparam int REF_MAX_LEN  = 16;
    localparam int READ_MAX_LEN = 8;   // one PE per read base
    localparam int SCORE_W      = 10;

    typedef logic [1:0]                                base_t;
    typedef logic signed [SCORE_W-1:0]                 score_t;
    typedef base_t [REF_MAX_LEN-1:0]                   ref_seq_t;   // [k] is reference base k
    typedef base_t [READ_MAX_LEN-1:0]                  read_seq_t;  // [k] is read base k
    typedef logic [$clog2(REF_MAX_LEN):0]              ref_len_t;   // 1-based
    typedef logic [$clog2(READ_MAX_LEN):0]             read_len_t;  // 1-based
    typedef logic [$clog2(REF_MAX_LEN)-1:0]            col_t;
    typedef logic [$clog2(READ_MAX_LEN)-1:0]           row_t;
    typedef logic [$clog2(REF_MAX_LEN+READ_MAX_LEN):0] step_t;

    // affine gap scoring
    localparam score_t MATCH_SCORE    = score_t'(2);
    localparam score_t MISMATCH_SCORE = score_t'(-1);
    localparam score_t GAP_OPEN       = score_t'(-2);
    localparam score_t GAP_EXTEND     = score_t'(-1);

    // control FSM
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_LOAD = 3'd1;
    localparam logic [2:0] ST_RUN  = 3'd2;
    localparam logic [2:0] ST_SCAN = 3'd3;
    localparam logic [2:0] ST_DONE = 3'd4;

endpackage

`default_nettype wire

//--- rtl/sw_pe.sv
// Systolic processing element computing align, insert and delete scores for one read base
`default_nettype none
`timescale 1ns/100ps

module sw_pe (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_a_valid,
    input  wire sw_pkg::base_t  i_a_base,    // reference base
    input  wire sw_pkg::base_t  i_b_base,    // read base of this row
    input  wire sw_pkg::score_t i_m_diag,
    input  wire sw_pkg::score_t i_i_diag,
    input  wire sw_pkg::score_t i_d_diag,
    input  wire sw_pkg::score_t i_m_top,
    input  wire sw_pkg::score_t i_i_top,
    input  wire sw_pkg::score_t i_m_left,
    input  wire sw_pkg::score_t i_d_left,
    output sw_pkg::score_t      o_m,
    output sw_pkg::score_t      o_i,
    output sw_pkg::score_t      o_d,
    output sw_pkg::score_t      o_h,
    output logic                o_a_valid,
    output sw_pkg::base_t       o_a_base
);

    sw_pkg::score_t weight;
    sw_pkg::score_t diag_best;
    sw_pkg::score_t m_calc;
    sw_pkg::score_t i_calc;
    sw_pkg::score_t d_calc;

    function automatic sw_pkg::score_t max2(input sw_pkg::score_t a, input sw_pkg::score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        weight = (i_a_base == i_b_base) ? sw_pkg::MATCH_SCORE : sw_pkg::MISMATCH_SCORE;

        // same weight on all three diagonal paths
        diag_best = max2(max2(i_m_diag, i_i_diag), i_d_diag);
        m_calc    = max2('0, diag_best + weight);

        i_calc = max2('0, max2(i_m_top + sw_pkg::GAP_OPEN, i_i_top + sw_pkg::GAP_EXTEND));
        d_calc = max2('0, max2(i_m_left + sw_pkg::GAP_OPEN, i_d_left + sw_pkg::GAP_EXTEND));

        if (i_a_valid) begin
            o_m = m_calc;
            o_i = i_calc;
            o_d = d_calc;
        end else begin
            // no base here, hold the row's last scores
            o_m = i_m_left;
            o_i = '0;
            o_d = i_d_left;
        end

        o_h = max2(max2(o_m, o_i), o_d);   // all three are never negative
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_a_valid <= 1'b0;
        end else begin
            o_a_valid <= i_a_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_a_base <= i_a_base;   // on to the next row
    end

endmodule

`default_nettype wire

//--- rtl/sw_pe_array.sv
// PE chain with the reference shifter, read bases and the per-row score delay registers
`default_nettype none
`timescale 1ns/100ps

module sw_pe_array (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_load,
    input  wire                   i_run,
    input  wire                   i_feed,
    input  wire sw_pkg::ref_seq_t i_ref,
    input  wire sw_pkg::read_seq_t i_read,
    output sw_pkg::score_t        o_cell_score [sw_pkg::READ_MAX_LEN]
);

    sw_pkg::ref_seq_t  ref_sr;
    sw_pkg::read_seq_t read_q;

    logic              a_valid_in [sw_pkg::READ_MAX_LEN];
    sw_pkg::base_t     a_base_in  [sw_pkg::READ_MAX_LEN];
    logic              a_valid    [sw_pkg::READ_MAX_LEN];
    sw_pkg::base_t     a_base     [sw_pkg::READ_MAX_LEN];

    sw_pkg::score_t    m_top  [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    i_top  [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    m_diag [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    i_diag [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    d_diag [sw_pkg::READ_MAX_LEN];

    sw_pkg::score_t    pe_m [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    pe_i [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    pe_d [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    pe_h [sw_pkg::READ_MAX_LEN];

    // one cycle back: left of this row, top of the next
    sw_pkg::score_t    m_d1 [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    i_d1 [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    d_d1 [sw_pkg::READ_MAX_LEN];
    // two cycles back: diagonal of the next row
    sw_pkg::score_t    m_d2 [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    i_d2 [sw_pkg::READ_MAX_LEN];
    sw_pkg::score_t    d_d2 [sw_pkg::READ_MAX_LEN];

    for (genvar j = 0; j < sw_pkg::READ_MAX_LEN; j++) begin : g_row
        if (j == 0) begin : g_first
            assign a_valid_in[j] = i_feed;
            assign a_base_in[j]  = ref_sr[0];
            assign m_top[j]      = '0;   // above the matrix
            assign i_top[j]      = '0;
            assign m_diag[j]     = '0;
            assign i_diag[j]     = '0;
            assign d_diag[j]     = '0;
        end else begin : g_next
            // gated so the valid chain is flushed during the load cycle
            assign a_valid_in[j] = a_valid[j-1] && i_run;
            assign a_base_in[j]  = a_base[j-1];
            assign m_top[j]      = m_d1[j-1];
            assign i_top[j]      = i_d1[j-1];
            assign m_diag[j]     = m_d2[j-1];
            assign i_diag[j]     = i_d2[j-1];
            assign d_diag[j]     = d_d2[j-1];
        end

        sw_pe u_pe (
            .clk       (clk),
            .rst       (rst),
            .i_a_valid (a_valid_in[j]),
            .i_a_base  (a_base_in[j]),
            .i_b_base  (read_q[j]),
            .i_m_diag  (m_diag[j]),
            .i_i_diag  (i_diag[j]),
            .i_d_diag  (d_diag[j]),
            .i_m_top   (m_top[j]),
            .i_i_top   (i_top[j]),
            .i_m_left  (m_d1[j]),
            .i_d_left  (d_d1[j]),
            .o_m       (pe_m[j]),
            .o_i       (pe_i[j]),
            .o_d       (pe_d[j]),
            .o_h       (pe_h[j]),
            .o_a_valid (a_valid[j]),
            .o_a_base  (a_base[j])
        );
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            ref_sr <= i_ref;
            read_q <= i_read;
        end else if (i_run) begin
            ref_sr <= ref_sr >> $bits(sw_pkg::base_t);   // base 0 enters first
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < sw_pkg::READ_MAX_LEN; j++) begin
            if (i_load) begin
                m_d1[j]         <= '0;
                i_d1[j]         <= '0;
                d_d1[j]         <= '0;
                m_d2[j]         <= '0;
                i_d2[j]         <= '0;
                d_d2[j]         <= '0;
                o_cell_score[j] <= '0;
            end else if (i_run) begin
                m_d1[j]         <= pe_m[j];
                i_d1[j]         <= pe_i[j];
                d_d1[j]         <= pe_d[j];
                m_d2[j]         <= m_d1[j];
                i_d2[j]         <= i_d1[j];
                d_d2[j]         <= d_d1[j];
                o_cell_score[j] <= pe_h[j];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_control.sv
// Engine FSM sequencing load, systolic run and row scan, with the valid/ready handshakes
`default_nettype none
`timescale 1ns/100ps

module sw_control (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_valid,
    input  wire                    i_ready,
    input  wire sw_pkg::ref_len_t  i_ref_len,
    input  wire sw_pkg::read_len_t i_read_len,
    output logic                   o_ready,
    output logic                   o_valid,
    output logic                   o_load,
    output logic                   o_run,
    output logic                   o_feed,
    output sw_pkg::step_t          o_step,
    output logic                   o_scan,
    output sw_pkg::row_t           o_scan_row
);

    logic [2:0]        state;
    sw_pkg::step_t     step;        // run step, then scan row
    sw_pkg::ref_len_t  ref_len_q;
    sw_pkg::read_len_t read_len_q;
    sw_pkg::step_t     run_last;
    sw_pkg::step_t     scan_last;

    // wavefront needs ref_len+read_len steps to leave the last row
    assign run_last  = sw_pkg::step_t'(ref_len_q) + sw_pkg::step_t'(read_len_q) - 1'b1;
    assign scan_last = sw_pkg::step_t'(read_len_q) - 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sw_pkg::ST_IDLE;
            step  <= '0;
        end else begin
            case (state)
                sw_pkg::ST_IDLE: begin
                    if (i_valid) begin
                        state <= sw_pkg::ST_LOAD;
                    end
                end
                sw_pkg::ST_LOAD: begin
                    state <= sw_pkg::ST_RUN;
                    step  <= '0;
                end
                sw_pkg::ST_RUN: begin
                    if (step == run_last) begin
                        state <= sw_pkg::ST_SCAN;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                sw_pkg::ST_SCAN: begin
                    if (step == scan_last) begin
                        state <= sw_pkg::ST_DONE;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                sw_pkg::ST_DONE: begin
                    if (i_ready) begin
                        state <= sw_pkg::ST_IDLE;   // result taken
                    end
                end
                default: state <= sw_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_load) begin
            ref_len_q  <= i_ref_len;
            read_len_q <= i_read_len;
        end
    end

    assign o_ready    = (state == sw_pkg::ST_IDLE);
    assign o_load     = o_ready && i_valid;   // acceptance edge
    assign o_run      = (state == sw_pkg::ST_RUN);
    assign o_feed     = o_run && (step < sw_pkg::step_t'(ref_len_q));
    assign o_step     = step;
    assign o_scan     = (state == sw_pkg::ST_SCAN);
    assign o_scan_row = sw_pkg::row_t'(step);
    assign o_valid    = (state == sw_pkg::ST_DONE);

endmodule

`default_nettype wire

//--- rtl/sw_best_cell.sv
// Best-cell tracker keeping per-row maxima during the run, then scanning rows for the top score
`default_nettype none
`timescale 1ns/100ps

module sw_best_cell (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_load,
    input  wire                 i_run,
    input  wire sw_pkg::step_t  i_step,
    input  wire sw_pkg::score_t i_cell_score [sw_pkg::READ_MAX_LEN],
    input  wire                 i_scan,
    input  wire sw_pkg::row_t   i_scan_row,
    output sw_pkg::score_t      o_score,
    output sw_pkg::row_t        o_row,
    output sw_pkg::col_t        o_col
);

    sw_pkg::score_t row_max [sw_pkg::READ_MAX_LEN];
    sw_pkg::col_t   row_col [sw_pkg::READ_MAX_LEN];

    // score arriving in row j at step s is column s-j-1
    always_ff @(posedge clk) begin
        for (int j = 0; j < sw_pkg::READ_MAX_LEN; j++) begin
            if (i_load) begin
                row_max[j] <= '0;
                row_col[j] <= '0;
            end else if (i_run && (i_cell_score[j] > row_max[j])) begin
                row_max[j] <= i_cell_score[j];   // strict, earliest column kept
                row_col[j] <= sw_pkg::col_t'(i_step - sw_pkg::step_t'(j + 1));
            end
        end
    end

    // rows scanned upward so ties stay on the lower row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_score <= '0;
            o_row   <= '0;
            o_col   <= '0;
        end else if (i_load) begin
            o_score <= '0;
            o_row   <= '0;
            o_col   <= '0;
        end else if (i_scan && (row_max[i_scan_row] > o_score)) begin
            o_score <= row_max[i_scan_row];
            o_row   <= i_scan_row;
            o_col   <= row_col[i_scan_row];
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_core.sv
// Smith-Waterman local alignment engine top, joining control, PE array and best-cell search
`default_nettype none
`timescale 1ns/100ps

module sw_core (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_valid,
    output wire                    o_ready,
    input  wire sw_pkg::ref_seq_t  i_ref,
    input  wire sw_pkg::read_seq_t i_read,
    input  wire sw_pkg::ref_len_t  i_ref_len,
    input  wire sw_pkg::read_len_t i_read_len,
    input  wire                    i_ready,
    output wire                    o_valid,
    output wire sw_pkg::score_t    o_score,
    output wire sw_pkg::row_t      o_row,
    output wire sw_pkg::col_t      o_col
);

    wire                 load;
    wire                 run;
    wire                 feed;
    wire                 scan;
    wire sw_pkg::step_t  step;
    wire sw_pkg::row_t   scan_row;
    wire sw_pkg::score_t cell_score [sw_pkg::READ_MAX_LEN];   // one per row

    sw_control u_control (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_ready    (i_ready),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_load     (load),
        .o_run      (run),
        .o_feed     (feed),
        .o_step     (step),
        .o_scan     (scan),
        .o_scan_row (scan_row)
    );

    sw_pe_array u_array (
        .clk          (clk),
        .rst          (rst),
        .i_load       (load),
        .i_run        (run),
        .i_feed       (feed),
        .i_ref        (i_ref),
        .i_read       (i_read),
        .o_cell_score (cell_score)
    );

    sw_best_cell u_best (
        .clk          (clk),
        .rst          (rst),
        .i_load       (load),
        .i_run        (run),
        .i_step       (step),
        .i_cell_score (cell_score),
        .i_scan       (scan),
        .i_scan_row   (scan_row),
        .o_score      (o_score),
        .o_row        (o_row),
        .o_col        (o_col)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// Clock and reset source for the alignment engine testbench
`default_nettype none
`timescale 1ns/100ps

module tb_clock (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD  = 5;   // 10 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst = 1'b0;   // released like any other stimulus
    end

endmodule

`default_nettype wire

//--- bench/sw_core_tb.sv
// Testbench for the alignment engine with directed and random jobs checked against a software model
`default_nettype none
`timescale 1ns/100ps

module sw_core_tb;

    localparam int CYCLE_LIMIT = 2000;   // 25 jobs of at most 40 cycles each plus margin

    wire                    clk;
    wire                    rst;
    logic                   job_valid;
    wire                    job_ready;
    sw_pkg::ref_seq_t       ref_seq;
    sw_pkg::read_seq_t      read_seq;
    sw_pkg::ref_len_t       ref_len;
    sw_pkg::read_len_t      read_len;
    logic                   res_ready;
    wire                    res_valid;
    wire sw_pkg::score_t    res_score;
    wire sw_pkg::row_t      res_row;
    wire sw_pkg::col_t      res_col;
    integer                 seed = 32'hf90dd7fe;
    int                     cycle_count = 0;

    tb_clock u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    sw_core dut (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (job_valid),
        .o_ready    (job_ready),
        .i_ref      (ref_seq),
        .i_read     (read_seq),
        .i_ref_len  (ref_len),
        .i_read_len (read_len),
        .i_ready    (res_ready),
        .o_valid    (res_valid),
        .o_score    (res_score),
        .o_row      (res_row),
        .o_col      (res_col)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic check_score(input sw_pkg::score_t got, input sw_pkg::score_t exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s score %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_pos(input sw_pkg::row_t got_row, input sw_pkg::row_t exp_row,
                             input sw_pkg::col_t got_col, input sw_pkg::col_t exp_col,
                             input string what);
        if (got_row !== exp_row || got_col !== exp_col) begin
            abort_run($sformatf("FAIL at %0t: %s row %0d col %0d, expected row %0d col %0d",
                                $time, what, got_row, got_col, exp_row, exp_col));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int max_int(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // character k of the text becomes base k
    function automatic sw_pkg::ref_seq_t encode_bases(input string text);
        sw_pkg::ref_seq_t seq;
        int               k;
        seq = '0;
        for (k = 0; k < text.len() && k < sw_pkg::REF_MAX_LEN; k++) begin
            case (text[k])
                "C":     seq[k] = 2'd1;
                "G":     seq[k] = 2'd2;
                "T":     seq[k] = 2'd3;
                default: seq[k] = 2'd0;
            endcase
        end
        return seq;
    endfunction

    // affine-gap matrices with a zero border in row 0 and column 0
    task automatic expected_result(input sw_pkg::ref_seq_t r, input sw_pkg::read_seq_t q,
                                   input sw_pkg::ref_len_t rl, input sw_pkg::read_len_t ql,
                                   output sw_pkg::score_t score, output sw_pkg::row_t row,
                                   output sw_pkg::col_t col);
        int m_mat [sw_pkg::READ_MAX_LEN+1][sw_pkg::REF_MAX_LEN+1];
        int i_mat [sw_pkg::READ_MAX_LEN+1][sw_pkg::REF_MAX_LEN+1];
        int d_mat [sw_pkg::READ_MAX_LEN+1][sw_pkg::REF_MAX_LEN+1];
        int w;
        int h;
        int best;
        int best_row;
        int best_col;
        int i;
        int k;
        for (i = 0; i <= sw_pkg::READ_MAX_LEN; i++) begin
            for (k = 0; k <= sw_pkg::REF_MAX_LEN; k++) begin
                m_mat[i][k] = 0;
                i_mat[i][k] = 0;
                d_mat[i][k] = 0;
            end
        end
        best     = 0;
        best_row = 0;
        best_col = 0;
        for (i = 1; i <= int'(ql); i++) begin
            for (k = 1; k <= int'(rl); k++) begin
                w = (q[i-1] == r[k-1]) ? int'(sw_pkg::MATCH_SCORE) : int'(sw_pkg::MISMATCH_SCORE);
                m_mat[i][k] = max_int(0, max_int(max_int(m_mat[i-1][k-1], i_mat[i-1][k-1]),
                                                 d_mat[i-1][k-1]) + w);
                i_mat[i][k] = max_int(0, max_int(m_mat[i-1][k] + int'(sw_pkg::GAP_OPEN),
                                                 i_mat[i-1][k] + int'(sw_pkg::GAP_EXTEND)));
                d_mat[i][k] = max_int(0, max_int(m_mat[i][k-1] + int'(sw_pkg::GAP_OPEN),
                                                 d_mat[i][k-1] + int'(sw_pkg::GAP_EXTEND)));
                h = max_int(max_int(m_mat[i][k], i_mat[i][k]), d_mat[i][k]);
                if (h > best) begin   // first strict maximum in row-major order wins
                    best     = h;
                    best_row = i - 1;
                    best_col = k - 1;
                end
            end
        end
        score = sw_pkg::score_t'(best);
        row   = sw_pkg::row_t'(best_row);
        col   = sw_pkg::col_t'(best_col);
    endtask

    task automatic send_job(input sw_pkg::ref_seq_t r, input sw_pkg::read_seq_t q,
                            input sw_pkg::ref_len_t rl, input sw_pkg::read_len_t ql);
        logic accepted;
        ref_seq   = r;
        read_seq  = q;
        ref_len   = rl;
        read_len  = ql;
        job_valid = 1'b1;
        accepted  = 1'b0;
        while (!accepted) begin
            accepted = job_ready;   // taken on the coming edge
            next_cycle();
        end
        job_valid = 1'b0;
    endtask

    task automatic collect_result(output sw_pkg::score_t score, output sw_pkg::row_t row,
                                  output sw_pkg::col_t col);
        while (res_valid !== 1'b1) begin
            next_cycle();
        end
        score     = res_score;
        row       = res_row;
        col       = res_col;
        res_ready = 1'b1;
        next_cycle();
        res_ready = 1'b0;
        check_flag(res_valid, 1'b0, "o_valid after the result was taken");
    endtask

    task automatic run_and_compare(input sw_pkg::ref_seq_t r, input sw_pkg::read_seq_t q,
                                   input sw_pkg::ref_len_t rl, input sw_pkg::read_len_t ql,
                                   input string what);
        sw_pkg::score_t got_score;
        sw_pkg::score_t exp_score;
        sw_pkg::row_t   got_row;
        sw_pkg::row_t   exp_row;
        sw_pkg::col_t   got_col;
        sw_pkg::col_t   exp_col;
        send_job(r, q, rl, ql);
        collect_result(got_score, got_row, got_col);
        expected_result(r, q, rl, ql, exp_score, exp_row, exp_col);
        check_score(got_score, exp_score, what);
        check_pos(got_row, exp_row, got_col, exp_col, what);
    endtask

    task automatic test_reset_state();
        check_flag(job_ready, 1'b1, "o_ready after reset");
        check_flag(res_valid, 1'b0, "o_valid after reset");
    endtask

    task automatic test_identical();
        sw_pkg::ref_seq_t r;
        sw_pkg::score_t   score;
        sw_pkg::row_t     row;
        sw_pkg::col_t     col;
        r = encode_bases("ACGTTGCA");
        send_job(r, r[7:0], 5'd8, 4'd8);
        collect_result(score, row, col);
        check_score(score, sw_pkg::score_t'(16), "identical sequences");
        check_pos(row, 3'd7, col, 4'd7, "identical sequences");
    endtask

    task automatic test_mismatch();
        sw_pkg::ref_seq_t r;
        sw_pkg::ref_seq_t q;
        sw_pkg::score_t   score;
        sw_pkg::row_t     row;
        sw_pkg::col_t     col;
        r = encode_bases("AAAAAAAAAAAAAAAA");
        q = encode_bases("CCCCCCCC");
        send_job(r, q[7:0], 5'd16, 4'd8);
        collect_result(score, row, col);
        check_score(score, '0, "all mismatched");
        check_pos(row, '0, col, '0, "all mismatched");
    endtask

    task automatic test_gapped();
        sw_pkg::ref_seq_t r;
        sw_pkg::ref_seq_t q;
        r = encode_bases("ACGTACGTTGCA");
        q = encode_bases("ACGTCGTT");   // one reference base skipped
        run_and_compare(r, q[7:0], 5'd12, 4'd8, "read with deletion");
        q = encode_bases("ACGTGACG");   // one extra read base
        run_and_compare(r, q[7:0], 5'd12, 4'd8, "read with insertion");
    endtask

    task automatic test_random();
        sw_pkg::ref_seq_t  r;
        sw_pkg::read_seq_t q;
        sw_pkg::ref_len_t  rl;
        sw_pkg::read_len_t ql;
        int                n;
        int                k;
        for (n = 0; n < 20; n++) begin
            for (k = 0; k < sw_pkg::REF_MAX_LEN; k++) begin
                r[k] = sw_pkg::base_t'($random(seed));
            end
            for (k = 0; k < sw_pkg::READ_MAX_LEN; k++) begin
                q[k] = sw_pkg::base_t'($random(seed));
            end
            rl = sw_pkg::ref_len_t'(1 + $unsigned($random(seed)) % sw_pkg::REF_MAX_LEN);
            ql = sw_pkg::read_len_t'(1 + $unsigned($random(seed)) % sw_pkg::READ_MAX_LEN);
            run_and_compare(r, q, rl, ql, $sformatf("random job %0d", n));
        end
    endtask

    task automatic test_back_pressure();
        sw_pkg::ref_seq_t r;
        sw_pkg::ref_seq_t q;
        sw_pkg::score_t   held_score;
        sw_pkg::score_t   exp_score;
        sw_pkg::row_t     held_row;
        sw_pkg::row_t     exp_row;
        sw_pkg::col_t     held_col;
        sw_pkg::col_t     exp_col;
        r = encode_bases("GATTACAGATTACA");
        q = encode_bases("TTACAG");
        send_job(r, q[7:0], 5'd14, 4'd6);
        while (res_valid !== 1'b1) begin
            next_cycle();
        end
        held_score = res_score;
        held_row   = res_row;
        held_col   = res_col;
        repeat (10) begin
            next_cycle();
            check_flag(res_valid, 1'b1, "o_valid while held");
            check_flag(job_ready, 1'b0, "o_ready while held");
            check_score(res_score, held_score, "held result");
            check_pos(res_row, held_row, res_col, held_col, "held result");
        end
        collect_result(held_score, held_row, held_col);
        check_flag(job_ready, 1'b1, "o_ready after release");
        expected_result(r, q[7:0], 5'd14, 4'd6, exp_score, exp_row, exp_col);
        check_score(held_score, exp_score, "back-pressure job");
        check_pos(held_row, exp_row, held_col, exp_col, "back-pressure job");
    endtask

    initial begin
        job_valid = 1'b0;
        res_ready = 1'b0;
        ref_seq   = '0;
        read_seq  = '0;
        ref_len   = '0;
        read_len  = '0;
        @(negedge rst);
        next_cycle();
        test_reset_state();
        test_identical();
        test_mismatch();
        test_gapped();
        test_random();
        test_back_pressure();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/sw_pkg.sv
rtl/sw_pe.sv
rtl/sw_pe_array.sv
rtl/sw_control.sv
rtl/sw_best_cell.sv
rtl/sw_core.sv
bench/tb_clock.sv
bench/sw_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the alignment engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module sw_core_tb -f build.f -Mdir obj_dir -o sw_core_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sw_core_sim)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "=== PASS ==="; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
